// ==== spi_periph_top.f ====
+incdir+logic
logic/spi_periph_pkg.sv
logic/spi_frame_link.sv
logic/spi_reg_bank.sv
logic/spi_mailbox.sv
logic/spi_reply_mux.sv
logic/spi_periph_top.sv
test/spi_periph_tb.sv

// ==== Makefile ====
BIN  := obj_dir/Vspi_periph_tb
SRCS := $(wildcard logic/*.sv logic/*.svh test/*.sv) spi_periph_top.f

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		-f spi_periph_top.f --top-module spi_periph_tb -o Vspi_periph_tb

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// ==== test/spi_periph_tb.sv ====
// Testbench for the SPI peripheral: SPI master and host credit models that run
// register, aborted-frame and mailbox scenarios, checked by immediate assertions.
`timescale 1ns/1ns
`default_nettype none
`include "spi_periph_config.svh"

module spi_periph_tb;

  logic        clk = 1'b0;
  logic        reset;
  logic        spi_sck;
  logic        spi_ss;
  logic        spi_mosi;
  logic        mbox_credit;
  logic        spi_miso;
  logic        mbox_valid;
  logic [15:0] mbox_data;

  logic [15:0] exp_words [$];  // Pushed words not yet seen by the host
  logic [15:0] ref_regs [`REG_COUNT];
  int          model_credits;
  int          delivered;
  integer      seed;

  spi_periph_top u_dut (
    .clk         (clk),
    .reset       (reset),
    .spi_sck     (spi_sck),
    .spi_ss      (spi_ss),
    .spi_mosi    (spi_mosi),
    .mbox_credit (mbox_credit),
    .spi_miso    (spi_miso),
    .mbox_valid  (mbox_valid),
    .mbox_data   (mbox_data)
  );

  always #5 clk = ~clk;

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else fail_stop($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Host side: every handover must spend a credit and follow push order
  always @(negedge clk) begin
    if (!reset && mbox_valid) begin
      assert (model_credits > 0) else fail_stop("mbox_valid fired with no host credit");
      assert (exp_words.size() > 0) else fail_stop("mbox_valid fired with no word queued");
      check_value("mbox_data", 32'(mbox_data), 32'(exp_words.pop_front()));
      model_credits--;
      delivered++;
    end
  end

  // Mode 0 master, SCK half period of 4 clk, MSB first
  task automatic shift_frame(input spi_periph_pkg::spi_frame_t tx, input int nbits,
                             output spi_periph_pkg::spi_reply_t rx);
    rx     = '0;
    spi_ss = 1'b0;
    idle(4);
    for (int i = 0; i < nbits; i++) begin
      spi_mosi = tx[`SPI_FRAME_BITS - 1 - i];
      idle(4);
      rx      = {rx[`SPI_FRAME_BITS-2:0], spi_miso};
      spi_sck = 1'b1;
      idle(4);
      spi_sck = 1'b0;
    end
    idle(4);
    spi_ss = 1'b1;
    idle(10);  // Frame decode and consumer updates settle
  endtask

  task automatic send_frame(input spi_periph_pkg::spi_op_e op, input logic [3:0] addr,
                            input logic [15:0] data, output spi_periph_pkg::spi_reply_t rx);
    spi_periph_pkg::spi_frame_t f;
    f.op   = op;
    f.addr = addr;
    f.data = data;
    shift_frame(f, `SPI_FRAME_BITS, rx);
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [15:0] data);
    spi_periph_pkg::spi_reply_t rx;
    ref_regs[addr % `REG_COUNT] = data;
    send_frame(spi_periph_pkg::OP_WRITE_REG, addr, data, rx);
  endtask

  task automatic read_reg(input logic [3:0] addr);
    spi_periph_pkg::spi_reply_t rx;
    send_frame(spi_periph_pkg::OP_READ_REG, addr, 16'd0, rx);
    send_frame(spi_periph_pkg::OP_NOP, 4'd0, 16'd0, rx);  // Carries the read reply
    check_value("read echo", 32'(rx.echo), 32'({spi_periph_pkg::OP_READ_REG, addr}));
    check_value("read data", 32'(rx.data), 32'(ref_regs[addr % `REG_COUNT]));
  endtask

  task automatic expect_status(input int level, input int credits, input int dropped);
    spi_periph_pkg::spi_reply_t   rx;
    spi_periph_pkg::mbox_status_t exp;
    exp.level   = 4'(level);
    exp.credits = 4'(credits);
    exp.dropped = 8'(dropped);
    send_frame(spi_periph_pkg::OP_STATUS, 4'd0, 16'd0, rx);
    send_frame(spi_periph_pkg::OP_NOP, 4'd0, 16'd0, rx);
    check_value("status echo", 32'(rx.echo), 32'({spi_periph_pkg::OP_STATUS, 4'd0}));
    check_value("status data", 32'(rx.data), 32'(exp));
  endtask

  task automatic push_word(input logic [15:0] data);
    spi_periph_pkg::spi_reply_t rx;
    if (exp_words.size() < `MBOX_DEPTH) begin
      exp_words.push_back(data);  // A full queue drops the word
    end
    send_frame(spi_periph_pkg::OP_MBOX_PUSH, 4'd0, data, rx);
  endtask

  task automatic return_credit();
    model_credits++;
    mbox_credit = 1'b1;
    idle(1);
    mbox_credit = 1'b0;
  endtask

  task automatic wait_delivered(input int count, input int limit);
    int t;
    t = 0;
    while (delivered < count && t < limit) begin
      @(negedge clk);
      t++;
    end
    assert (delivered >= count)
      else fail_stop($sformatf("Timeout waiting for mailbox word %0d at the host", count));
  endtask

  initial begin
    spi_periph_pkg::spi_reply_t   rx;
    spi_periph_pkg::spi_frame_t   cut;
    reset         = 1'b1;
    spi_sck       = 1'b0;
    spi_ss        = 1'b1;
    spi_mosi      = 1'b0;
    mbox_credit   = 1'b0;
    seed          = 79;
    model_credits = `MBOX_CREDITS;
    delivered     = 0;
    idle(5);
    reset = 1'b0;
    idle(2);

    check_value("mbox_valid", 32'(mbox_valid), 32'd0);
    check_value("spi_miso", 32'(spi_miso), 32'd0);
    send_frame(spi_periph_pkg::OP_NOP, 4'd0, 16'd0, rx);
    check_value("reply after reset", 32'(rx), 32'd0);
    expect_status(0, `MBOX_CREDITS, 0);

    for (int i = 0; i < `REG_COUNT; i++) begin
      write_reg(4'(i), 16'($random(seed)));
    end
    for (int i = 0; i < `REG_COUNT; i++) begin
      read_reg(4'((i % 2 == 1) ? i + `REG_COUNT : i));  // Odd ones via alias
    end
    write_reg(4'(2 + `REG_COUNT), 16'($random(seed)));
    read_reg(4'd2);

    // Frames cut after 12 bits
    cut.op   = spi_periph_pkg::OP_WRITE_REG;
    cut.addr = 4'd3;
    cut.data = ~ref_regs[3];
    shift_frame(cut, 12, rx);
    cut.op = spi_periph_pkg::OP_MBOX_PUSH;
    shift_frame(cut, 12, rx);
    idle(20);
    read_reg(4'd3);

    for (int i = 0; i < 3; i++) begin
      push_word(16'($random(seed)));
    end
    wait_delivered(`MBOX_CREDITS, 200);
    idle(40);
    return_credit();
    wait_delivered(3, 200);

    for (int i = 0; i < `MBOX_DEPTH + 2; i++) begin
      push_word(16'($random(seed)));
    end
    expect_status(`MBOX_DEPTH, 0, 2);
    for (int i = 0; i < `MBOX_DEPTH; i++) begin
      return_credit();
    end
    wait_delivered(3 + `MBOX_DEPTH, 200);
    idle(20);
    expect_status(0, 0, 2);

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/spi_periph_top.sv ====
// SPI target peripheral top: frame link, scratch registers, host mailbox
// and reply mux. SCK must stay below a quarter of clk.
`timescale 1ns/1ns
`default_nettype none

module spi_periph_top (
  input  wire         clk,
  input  wire         reset,
  input  wire         spi_sck,
  input  wire         spi_ss,
  input  wire         spi_mosi,
  input  wire         mbox_credit,
  output logic        spi_miso,
  output logic        mbox_valid,
  output logic [15:0] mbox_data
);

  spi_periph_pkg::spi_frame_t   frame;
  logic                         frame_valid;
  logic [15:0]                  rd_data;
  spi_periph_pkg::mbox_status_t status;
  spi_periph_pkg::spi_reply_t   reply;

  spi_frame_link u_link (
    .clk         (clk),
    .reset       (reset),
    .spi_sck     (spi_sck),
    .spi_ss      (spi_ss),
    .spi_mosi    (spi_mosi),
    .reply       (reply),
    .spi_miso    (spi_miso),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  spi_reg_bank u_regs (
    .clk         (clk),
    .reset       (reset),
    .frame       (frame),
    .frame_valid (frame_valid),
    .rd_data     (rd_data)
  );

  spi_mailbox u_mbox (
    .clk         (clk),
    .reset       (reset),
    .frame       (frame),
    .frame_valid (frame_valid),
    .mbox_credit (mbox_credit),
    .mbox_valid  (mbox_valid),
    .mbox_data   (mbox_data),
    .status      (status)
  );

  spi_reply_mux u_reply (
    .clk         (clk),
    .reset       (reset),
    .frame       (frame),
    .frame_valid (frame_valid),
    .rd_data     (rd_data),
    .status      (status),
    .reply       (reply)
  );

endmodule

`default_nettype wire

// ==== logic/spi_reply_mux.sv ====
// Builds the reply word for the next frame from the opcode byte and the
// register bank or mailbox result.
`timescale 1ns/1ns
`default_nettype none

module spi_reply_mux (
  input  wire                               clk,
  input  wire                               reset,
  input  wire spi_periph_pkg::spi_frame_t   frame,
  input  wire                               frame_valid,
  input  wire [15:0]                        rd_data,
  input  wire spi_periph_pkg::mbox_status_t status,
  output spi_periph_pkg::spi_reply_t        reply
);

  logic [15:0] data_sel;

  always_comb begin
    case (frame.op)
      spi_periph_pkg::OP_READ_REG: data_sel = rd_data;
      spi_periph_pkg::OP_STATUS:   data_sel = status;
      default:                     data_sel = frame.data;  // Echo written data
    endcase
  end

  // Held until the next complete frame
  always_ff @(posedge clk) begin
    if (reset) begin
      reply <= '0;
    end else if (frame_valid) begin
      reply.echo <= {frame.op, frame.addr};
      reply.data <= data_sel;
    end
  end

endmodule

`default_nettype wire

// ==== logic/spi_mailbox.sv ====
// Master-to-host mailbox: circular queue filled by OP_MBOX_PUSH frames and
// drained toward the host one word per credit.
`timescale 1ns/1ns
`default_nettype none
`include "spi_periph_config.svh"

module spi_mailbox (
  input  wire                               clk,
  input  wire                               reset,
  input  wire spi_periph_pkg::spi_frame_t   frame,
  input  wire                               frame_valid,
  input  wire                               mbox_credit,
  output logic                              mbox_valid,
  output logic [15:0]                       mbox_data,
  output spi_periph_pkg::mbox_status_t      status
);

  localparam int DEPTH = `MBOX_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int LVL_W = $clog2(DEPTH + 1);

  logic [15:0]      mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [LVL_W-1:0] level;
  logic [3:0]       credits;
  logic [7:0]       dropped;
  logic             push_req;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push_req = frame_valid && (frame.op == spi_periph_pkg::OP_MBOX_PUSH);
  assign push     = push_req && (level != LVL_W'(DEPTH));
  assign pop      = (level != '0) && (credits != '0);  // Host must hold a credit

  assign status = '{level: 4'(level), credits: credits, dropped: dropped};

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      level      <= '0;
      credits    <= 4'(`MBOX_CREDITS);
      dropped    <= '0;
      mbox_valid <= 1'b0;
    end else begin
      mbox_valid <= pop;
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (push_req && !push && dropped != 8'hff) begin
        dropped <= dropped + 8'd1;
      end
      case ({push, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: ;
      endcase
      case ({pop, mbox_credit})
        2'b10:   credits <= credits - 4'd1;
        2'b01:   credits <= credits + 4'd1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= frame.data;
    end
    if (pop) begin
      mbox_data <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

// ==== logic/spi_reg_bank.sv ====
// Scratch register bank. OP_WRITE_REG frames write it; the register at the
// frame address is always presented on rd_data.
`timescale 1ns/1ns
`default_nettype none
`include "spi_periph_config.svh"

module spi_reg_bank (
  input  wire                             clk,
  input  wire                             reset,
  input  wire spi_periph_pkg::spi_frame_t frame,
  input  wire                             frame_valid,
  output logic [15:0]                     rd_data
);

  localparam int AW = $clog2(`REG_COUNT);

  logic [15:0]   regs [`REG_COUNT];
  logic [AW-1:0] idx;
  logic          wr_en;

  // Upper address bits alias
  assign idx   = frame.addr[AW-1:0];
  assign wr_en = frame_valid && (frame.op == spi_periph_pkg::OP_WRITE_REG);

  assign rd_data = regs[idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[idx] <= frame.data;
    end
  end

endmodule

`default_nettype wire

// ==== logic/spi_frame_link.sv ====
// SPI mode 0 target link: synchronizes the pins, assembles 24-bit frames
// and shifts the reply word out on MISO during the next frame.
`timescale 1ns/1ns
`default_nettype none
`include "spi_periph_config.svh"

module spi_frame_link (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        spi_sck,
  input  wire                        spi_ss,
  input  wire                        spi_mosi,
  input  wire spi_periph_pkg::spi_reply_t reply,
  output logic                       spi_miso,
  output spi_periph_pkg::spi_frame_t frame,
  output logic                       frame_valid
);

  localparam int FB    = `SPI_FRAME_BITS;
  localparam int CNT_W = $clog2(FB + 1) + 1;

  logic [2:0]       sck_sync;  // Two sync stages plus edge history
  logic [2:0]       ss_sync;
  logic [1:0]       mosi_sync;
  logic [CNT_W-1:0] bit_cnt;
  logic [FB-1:0]    rx_shift;
  logic [FB-1:0]    tx_shift;

  logic sck_rise;
  logic sck_fall;
  logic ss_rise;
  logic ss_fall;
  logic ss_low;

  assign sck_rise = sck_sync[1] & ~sck_sync[2];
  assign sck_fall = ~sck_sync[1] & sck_sync[2];
  assign ss_rise  = ss_sync[1] & ~ss_sync[2];
  assign ss_fall  = ~ss_sync[1] & ss_sync[2];
  assign ss_low   = ~ss_sync[1];

  assign spi_miso = tx_shift[FB-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      sck_sync    <= '0;
      ss_sync     <= '1;  // Idle deselected
      mosi_sync   <= '0;
      bit_cnt     <= '0;
      tx_shift    <= '0;
      frame_valid <= 1'b0;
    end else begin
      sck_sync    <= {sck_sync[1:0], spi_sck};
      ss_sync     <= {ss_sync[1:0], spi_ss};
      mosi_sync   <= {mosi_sync[0], spi_mosi};
      frame_valid <= 1'b0;

      if (ss_fall) begin
        bit_cnt  <= '0;
        tx_shift <= reply;  // Reply of the previous frame
      end else if (ss_low) begin
        if (sck_rise && bit_cnt != '1) begin
          bit_cnt <= bit_cnt + 1'b1;  // Saturates on overlong frames
        end
        if (sck_fall) begin
          tx_shift <= {tx_shift[FB-2:0], 1'b0};
        end
      end

      // Only complete frames reach the consumers
      if (ss_rise) begin
        frame_valid <= (bit_cnt == CNT_W'(FB));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ss_low && sck_rise) begin
      rx_shift <= {rx_shift[FB-2:0], mosi_sync[1]};
    end
    if (ss_rise) begin
      frame <= spi_periph_pkg::spi_frame_t'(rx_shift);
    end
  end

endmodule

`default_nettype wire

// ==== logic/spi_periph_pkg.sv ====
// Shared types of the SPI peripheral: opcodes, decoded frame, reply word
// and mailbox status, referenced by scoped name.
`default_nettype none

package spi_periph_pkg;

  typedef enum logic [3:0] {
    OP_NOP       = 4'h0,
    OP_WRITE_REG = 4'h1,
    OP_READ_REG  = 4'h2,
    OP_MBOX_PUSH = 4'h3,
    OP_STATUS    = 4'h4
  } spi_op_e;

  // Received frame, MSB first on the wire
  typedef struct packed {
    spi_op_e     op;
    logic [3:0]  addr;
    logic [15:0] data;
  } spi_frame_t;

  typedef struct packed {
    logic [7:0]  echo;  // Opcode byte of the previous frame
    logic [15:0] data;
  } spi_reply_t;

  typedef struct packed {
    logic [3:0] level;
    logic [3:0] credits;
    logic [7:0] dropped;  // Saturates at 255
  } mbox_status_t;

endpackage

`default_nettype wire

// ==== logic/spi_periph_config.svh ====
// Size settings for the SPI peripheral: frame length, register bank and mailbox.
// Include wherever one of these sizes is needed.
`ifndef SPI_PERIPH_CONFIG_SVH
`define SPI_PERIPH_CONFIG_SVH

// Opcode byte plus 16-bit data word
`define SPI_FRAME_BITS 24

// Scratch registers, addressed modulo this count
`define REG_COUNT 8

// Mailbox queue entries
`define MBOX_DEPTH 4

// Credits the host grants after reset
`define MBOX_CREDITS 2

`endif
